//--- all.f
common/adventurePkg.sv
common/gameView.sv
hdl/stepTimer.sv
player/playerMotion.sv
items/keyTracker.sv
render/pixelCompositor.sv
hdl/adventureTop.sv
testbench/adventure_assertions.sv
testbench/adventureTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module adventureTb -f all.f -o adventureSim

./obj_dir/adventureSim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation passed"

//--- testbench/adventureTb.sv
module adventureTb
	import adventurePkg::*;
();

	localparam int ROWS = 12;
	localparam color_t MAP_FILL = 8'h55;
	localparam logic [3:0] BTN_NONE  = 4'b0000;
	localparam logic [3:0] BTN_RIGHT = 4'b0001;
	localparam logic [3:0] BTN_DOWN  = 4'b0010;
	localparam logic [3:0] BTN_UP    = 4'b0100;
	localparam logic [3:0] BTN_LEFT  = 4'b1000;

	typedef struct packed {
		logic [3:0] buttons;
		int         steps;
		logic       echo;
		logic       blankProbe;
		pixelX_t    probeX;
		pixelY_t    probeY;
		color_t     expColor;
		roomCoord_t expRoomX;
		roomCoord_t expRoomY;
		color_t     expRoomColor;
	} row_t;

	logic       turn;
	logic       rst;
	logic [3:0] buttons;
	pixelX_t    pixelX;
	pixelY_t    pixelY;
	logic       blank;
	color_t     mapPixel;
	color_t     color;
	roomCoord_t roomX;
	roomCoord_t roomY;
	color_t     roomColor;

	row_t rows [ROWS];
	int cycles;
	int cycleLimit;
	int errors;
	int failedRows;

	// Reference player state
	pixelX_t    mx;
	pixelY_t    my;
	roomCoord_t mrx;
	roomCoord_t mry;
	logic       bumpM;

	adventureTop u_dut (
		.turn      (turn),
		.rst       (rst),
		.buttons   (buttons),
		.pixelX    (pixelX),
		.pixelY    (pixelY),
		.blank     (blank),
		.mapPixel  (mapPixel),
		.color     (color),
		.roomX     (roomX),
		.roomY     (roomY),
		.roomColor (roomColor)
	);

	always #20 turn = ~turn;

	always @(posedge turn) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Returns on the edge where the DUT applies a game step
	task automatic waitStep();
		@(posedge turn);
		while (!u_dut.step)
			@(posedge turn);
	endtask

	task automatic modelStep(logic [3:0] b);
		pixelX_t ox;
		pixelY_t oy;
		ox = mx;
		oy = my;
		if (b[0] && ox < X_MAX)
			mx = bumpM ? ox - pixelX_t'(PUSH_BACK) : ox + 10'd1;
		if (b[1] && oy < Y_MAX)
			my = bumpM ? oy - pixelY_t'(PUSH_BACK) : oy + 9'd1;
		if (b[2] && oy > Y_MIN)
			my = bumpM ? oy + pixelY_t'(PUSH_BACK) : oy - 9'd1;
		if (b[3] && ox > X_MIN)
			mx = bumpM ? ox + pixelX_t'(PUSH_BACK) : ox - 10'd1;
		// No maze portals since the route never reaches the maze
		if (ox >= X_MAX && mrx != ROOM_LIMIT) begin
			mrx = mrx + 4'd1;
			mx = ENTRY_LEFT;
		end else if (oy >= Y_MAX && mry != ROOM_LIMIT) begin
			mry = mry + 4'd1;
			my = ENTRY_TOP;
		end else if (oy <= Y_MIN && mry != '0) begin
			mry = mry - 4'd1;
			my = ENTRY_BOTTOM;
		end else if (ox <= X_MIN && mrx != '0) begin
			mrx = mrx - 4'd1;
			mx = ENTRY_RIGHT;
		end
	endtask

	task automatic runRow(int i);
		row_t r;
		color_t got;
		int rowErrors;
		r = rows[i];
		rowErrors = 0;
		// Show the player centre once so bump follows the row's map colour
		@(posedge turn);
		pixelX <= mx;
		pixelY <= my;
		mapPixel <= r.echo ? roomColor : MAP_FILL;
		blank <= 1'b0;
		@(posedge turn);
		blank <= 1'b1;
		buttons <= r.buttons;
		bumpM = r.echo;
		for (int s = 0; s < r.steps; s++) begin
			waitStep();
			modelStep(r.buttons);
		end
		buttons <= BTN_NONE;
		waitStep();
		pixelX <= r.probeX;
		pixelY <= r.probeY;
		mapPixel <= MAP_FILL;
		blank <= r.blankProbe;
		@(posedge turn);
		@(negedge turn);
		got = color;
		assert (got === r.expColor) else begin
			$display("** Error at %0t: row %0d pixel (%0d,%0d) is %h, expected %h",
				$time, i, r.probeX, r.probeY, got, r.expColor);
			rowErrors++;
		end
		assert (roomX === r.expRoomX && roomY === r.expRoomY) else begin
			$display("** Error at %0t: row %0d room (%0d,%0d), expected (%0d,%0d)",
				$time, i, roomX, roomY, r.expRoomX, r.expRoomY);
			rowErrors++;
		end
		assert (roomColor === r.expRoomColor) else begin
			$display("** Error at %0t: row %0d room colour %h, expected %h",
				$time, i, roomColor, r.expRoomColor);
			rowErrors++;
		end
		@(posedge turn);
		blank <= 1'b1;
		errors += rowErrors;
		if (rowErrors != 0)
			failedRows++;
		$display("Row %0d: buttons %b for %0d steps, %s", i, r.buttons, r.steps,
			rowErrors == 0 ? "ok" : "mismatch");
	endtask

	initial begin
		turn = 1'b0;
		rst = 1'b1;
		buttons = BTN_NONE;
		pixelX = '0;
		pixelY = '0;
		blank = 1'b1;
		mapPixel = MAP_FILL;
		cycles = 0;
		errors = 0;
		failedRows = 0;
		mx = START_X;
		my = START_Y;
		mrx = START_ROOM_X;
		mry = START_ROOM_Y;
		bumpM = 1'b0;

		////////////////////
		// buttons, steps, echo, blank, probe x/y, colour, room x/y, room colour
		////////////////////
		rows[0]  = '{BTN_NONE, 0, 1'b0, 1'b0, 10'd320, 9'd380, COLOR_YELLOW, 4'd3, 4'd5,
			COLOR_YELLOW};
		rows[1]  = '{BTN_NONE, 0, 1'b0, 1'b1, 10'd320, 9'd380, 8'h00, 4'd3, 4'd5,
			COLOR_YELLOW};
		rows[2]  = '{BTN_RIGHT, 20, 1'b0, 1'b0, 10'd340, 9'd380, COLOR_YELLOW, 4'd3, 4'd5,
			COLOR_YELLOW};
		rows[3]  = '{BTN_NONE, 0, 1'b0, 1'b0, 10'd311, 9'd380, MAP_FILL, 4'd3, 4'd5,
			COLOR_YELLOW};
		// 370 steps to Y_MIN and one more to cross into the room above
		rows[4]  = '{BTN_UP, 371, 1'b0, 1'b0, 10'd340, 9'd466, COLOR_YELLOW, 4'd3, 4'd4,
			COLOR_YELLOW};
		// Push back to x 333
		rows[5]  = '{BTN_RIGHT, 1, 1'b1, 1'b0, 10'd325, 9'd466, COLOR_YELLOW, 4'd3, 4'd4,
			COLOR_YELLOW};
		rows[6]  = '{BTN_NONE, 0, 1'b0, 1'b0, 10'd345, 9'd466, MAP_FILL, 4'd3, 4'd4,
			COLOR_YELLOW};
		rows[7]  = '{BTN_LEFT, 193, 1'b0, 1'b0, 10'd140, 9'd466, COLOR_YELLOW, 4'd3, 4'd4,
			COLOR_YELLOW};
		// Back into the castle where the gate bar is still locked
		rows[8]  = '{BTN_DOWN, 5, 1'b0, 1'b0, 10'd304, 9'd290, COLOR_BLACK, 4'd3, 4'd5,
			COLOR_YELLOW};
		// Pick up the yellow key and probe it beside the player
		rows[9]  = '{BTN_DOWN, 206, 1'b0, 1'b0, 10'd170, 9'd221, COLOR_YELLOW, 4'd3, 4'd5,
			COLOR_YELLOW};
		rows[10] = '{BTN_DOWN, 135, 1'b0, 1'b0, 10'd170, 9'd356, COLOR_YELLOW, 4'd3, 4'd5,
			COLOR_YELLOW};
		rows[11] = '{BTN_RIGHT, 160, 1'b0, 1'b0, 10'd304, 9'd290, MAP_FILL, 4'd3, 4'd5,
			COLOR_YELLOW};

		cycleLimit = 200 + 16;
		for (int i = 0; i < ROWS; i++)
			cycleLimit += (rows[i].steps + 1) * STEP_PERIOD;

		repeat (16) @(posedge turn);
		rst <= 1'b0;

		for (int i = 0; i < ROWS; i++)
			runRow(i);

		$display("Rows run %0d, passed %0d, failed %0d, errors %0d",
			ROWS, ROWS - failedRows, failedRows, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- testbench/adventure_assertions.sv
module adventureAssertions
	import adventurePkg::*;
(
	input logic       turn,
	input logic       rst,
	input logic       blank,
	input color_t     color,
	input roomCoord_t roomX,
	input roomCoord_t roomY
);

	// Blanked pixels come out black on the next cycle
	blankBlack: assert property (@(posedge turn) disable iff (rst) blank |=> color == 8'h00)
		else $error("Colour not zero one cycle after blank");

	roomXRange: assert property (@(posedge turn) disable iff (rst) roomX <= ROOM_LIMIT)
		else $error("Room x beyond the room grid");

	roomYRange: assert property (@(posedge turn) disable iff (rst) roomY <= ROOM_LIMIT)
		else $error("Room y beyond the room grid");

endmodule

bind adventureTop adventureAssertions uChecks (
	.turn  (turn),
	.rst   (rst),
	.blank (blank),
	.color (color),
	.roomX (roomX),
	.roomY (roomY)
);

//--- hdl/adventureTop.sv
module adventureTop
	import adventurePkg::*;
(
	input  logic       turn,
	input  logic       rst,
	input  logic [3:0] buttons,
	input  pixelX_t    pixelX,
	input  pixelY_t    pixelY,
	input  logic       blank,
	input  color_t     mapPixel,
	output color_t     color,
	output roomCoord_t roomX,
	output roomCoord_t roomY,
	output color_t     roomColor
);

	logic step;
	logic bump;

	gameView view ();

	stepTimer uStep (
		.turn (turn),
		.rst  (rst),
		.step (step)
	);

	playerMotion uPlayer (
		.turn    (turn),
		.rst     (rst),
		.step    (step),
		.buttons (buttons),
		.bump    (bump),
		.view    (view.player)
	);

	keyTracker uKeys (
		.turn (turn),
		.rst  (rst),
		.step (step),
		.view (view.keys)
	);

	pixelCompositor uRender (
		.turn     (turn),
		.rst      (rst),
		.pixelX   (pixelX),
		.pixelY   (pixelY),
		.blank    (blank),
		.mapPixel (mapPixel),
		.view     (view.render),
		.color    (color),
		.bump     (bump)
	);

	// Room outputs feed the external map generator
	assign roomX     = view.roomX;
	assign roomY     = view.roomY;
	assign roomColor = view.roomColor;

endmodule

//--- render/pixelCompositor.sv
module pixelCompositor
	import adventurePkg::*;
(
	input  logic       turn,
	input  logic       rst,
	input  pixelX_t    pixelX,
	input  pixelY_t    pixelY,
	input  logic       blank,
	input  color_t     mapPixel,
	gameView.render    view,
	output color_t     color,
	output logic       bump
);

	logic inYellowCastle;
	logic inBlackCastle;
	logic gateShown;
	logic gateBar;
	logic yellowHit;
	logic blackHit;
	logic playerHit;
	logic gateZone;

	function automatic logic spanX(pixelX_t px, pixelX_t kx, int lo, int hi);
		return px >= kx + pixelX_t'(lo) && px <= kx + pixelX_t'(hi);
	endfunction

	// Three-row key outline, stem pointing left
	function automatic logic keyShape(pixelX_t px, pixelY_t py, pixelX_t kx, pixelY_t ky);
		logic topRow;
		logic midRow;
		logic lowRow;
		topRow = py >= ky - pixelY_t'(KEY_ROW) && py < ky;
		midRow = py >= ky && py < ky + pixelY_t'(KEY_ROW);
		lowRow = py >= ky + pixelY_t'(KEY_ROW) && py < ky + pixelY_t'(KEY_H);
		return (topRow && spanX(px, kx, 22, KEY_W))
			|| (midRow && (spanX(px, kx, 0, 24) || spanX(px, kx, 28, KEY_W)))
			|| (lowRow && (spanX(px, kx, 0, 4) || spanX(px, kx, 8, 12)
				|| spanX(px, kx, 22, KEY_W)));
	endfunction

	assign inYellowCastle = view.roomX == YELLOW_CASTLE_X && view.roomY == YELLOW_CASTLE_Y;
	assign inBlackCastle  = view.roomX == BLACK_CASTLE_X && view.roomY == BLACK_CASTLE_Y;
	assign gateShown = (inYellowCastle && !view.yellowUsed) || (inBlackCastle && !view.blackUsed);

	always_comb begin
		gateBar = 1'b0;
		for (int i = 0; i < GATE_BARS; i++) begin
			if (pixelX >= GATE_X + pixelX_t'(i * GATE_PITCH)
					&& pixelX < GATE_X + pixelX_t'(i * GATE_PITCH + GATE_BAR_W))
				gateBar = 1'b1;
		end
		gateBar = gateBar && pixelY >= GATE_Y && pixelY <= GATE_Y + pixelY_t'(GATE_BAR_H);
	end

	// Keys show in their home room or while carried
	assign yellowHit = !view.yellowUsed
		&& ((view.roomX == YELLOW_KEY_ROOM_X && view.roomY == YELLOW_KEY_ROOM_Y)
			|| view.held == HELD_YELLOW)
		&& keyShape(pixelX, pixelY, view.yellowKeyX, view.yellowKeyY);
	assign blackHit = !view.blackUsed
		&& ((view.roomX == BLACK_KEY_ROOM_X && view.roomY == BLACK_KEY_ROOM_Y)
			|| view.held == HELD_BLACK)
		&& keyShape(pixelX, pixelY, view.blackKeyX, view.blackKeyY);

	assign playerHit = pixelX >= view.playerX - pixelX_t'(PLAYER_HALF)
		&& pixelX < view.playerX + pixelX_t'(PLAYER_HALF)
		&& pixelY >= view.playerY - pixelY_t'(PLAYER_HALF)
		&& pixelY < view.playerY + pixelY_t'(PLAYER_HALF);

	// Player standing in front of a castle gate
	assign gateZone = view.playerX > UNLOCK_X_LO && view.playerY < GATE_BLOCK_Y;

	////////////////////
	// Output pixel
	////////////////////
	always_ff @(posedge turn) begin
		if (rst) begin
			color <= '0;
			bump <= 1'b0;
		end else if (blank) begin
			color <= '0;
		end else begin
			if (gateShown && gateBar)
				color <= COLOR_BLACK;
			else if (yellowHit)
				color <= COLOR_YELLOW;
			else if (blackHit)
				color <= COLOR_BLACK;
			else if (playerHit)
				color <= view.roomColor;
			else
				color <= mapPixel;

			// Bump by colour match, the gate decides on its own
			if (playerHit) begin
				if (inYellowCastle && gateZone)
					bump <= !view.yellowUsed;
				else if (inBlackCastle && gateZone)
					bump <= !view.blackUsed;
				else
					bump <= mapPixel == view.roomColor;
			end
		end
	end

endmodule

//--- items/keyTracker.sv
module keyTracker
	import adventurePkg::*;
(
	input  logic turn,
	input  logic rst,
	input  logic step,
	gameView.keys view
);

	logic inYellowKeyRoom;
	logic inBlackKeyRoom;
	logic atUnlockSpot;

	// Player centre inside the key box
	function automatic logic onKey(pixelX_t px, pixelY_t py, pixelX_t kx, pixelY_t ky);
		return px > kx && px < kx + pixelX_t'(KEY_W)
			&& py > ky - pixelY_t'(KEY_ROW) && py < ky + pixelY_t'(KEY_H);
	endfunction

	assign inYellowKeyRoom = view.roomX == YELLOW_KEY_ROOM_X && view.roomY == YELLOW_KEY_ROOM_Y;
	assign inBlackKeyRoom  = view.roomX == BLACK_KEY_ROOM_X && view.roomY == BLACK_KEY_ROOM_Y;
	assign atUnlockSpot = view.playerX > UNLOCK_X_LO && view.playerX < UNLOCK_X_HI
		&& view.playerY < UNLOCK_Y;

	always_ff @(posedge turn) begin
		if (rst) begin
			view.yellowKeyX <= YELLOW_KEY_X;
			view.yellowKeyY <= YELLOW_KEY_Y;
			view.blackKeyX <= BLACK_KEY_X;
			view.blackKeyY <= BLACK_KEY_Y;
			view.yellowUsed <= 1'b0;
			view.blackUsed <= 1'b0;
			view.held <= HELD_NONE;
		end else if (step) begin
			// Pickup, black wins if both touch
			if (inYellowKeyRoom && !view.yellowUsed
					&& onKey(view.playerX, view.playerY, view.yellowKeyX, view.yellowKeyY))
				view.held <= HELD_YELLOW;
			if (inBlackKeyRoom && !view.blackUsed
					&& onKey(view.playerX, view.playerY, view.blackKeyX, view.blackKeyY))
				view.held <= HELD_BLACK;

			if (view.held == HELD_YELLOW) begin
				view.yellowKeyX <= view.playerX + pixelX_t'(CARRY_OFFSET);
				view.yellowKeyY <= view.playerY;
				if (view.roomX == YELLOW_CASTLE_X && view.roomY == YELLOW_CASTLE_Y && atUnlockSpot)
					view.yellowUsed <= 1'b1;
			end
			if (view.held == HELD_BLACK) begin
				view.blackKeyX <= view.playerX + pixelX_t'(CARRY_OFFSET);
				view.blackKeyY <= view.playerY;
				if (view.roomX == BLACK_CASTLE_X && view.roomY == BLACK_CASTLE_Y && atUnlockSpot)
					view.blackUsed <= 1'b1;
			end
		end
	end

endmodule

//--- player/playerMotion.sv
module playerMotion
	import adventurePkg::*;
(
	input  logic       turn,
	input  logic       rst,
	input  logic       step,
	input  logic [3:0] buttons,
	input  logic       bump,
	gameView.player    view
);

	logic moveRight;
	logic moveDown;
	logic moveUp;
	logic moveLeft;

	// Destination room through the side edges
	roomCoord_t rightRoomX;
	roomCoord_t rightRoomY;
	roomCoord_t leftRoomX;
	roomCoord_t leftRoomY;

	function automatic color_t roomLookup(roomCoord_t x, roomCoord_t y);
		if (x == 4'd3 && y <= 4'd5)
			return COLOR_YELLOW;
		else if (x == 4'd4 && y == 4'd7)
			return COLOR_KEY_ROOM;
		else if (x == 4'd1 && y == 4'd1)
			return COLOR_CHALICE;
		else if (x == 4'd1 && y == 4'd2)
			return COLOR_BLACK_YARD;
		else if (x == 4'd1 && y == 4'd3)
			return COLOR_BLACK;
		else if (x == 4'd1 || (x == 4'd2 && y < 4'd6))
			return COLOR_MAZE;
		else if (x == 4'd2 && y == 4'd6)
			return COLOR_LEFT_HALL;
		else if (x == 4'd3 && y == 4'd6)
			return COLOR_GREEN;
		else if (x == 4'd4 && y == 4'd6)
			return COLOR_RIGHT_HALL;
		return COLOR_DEFAULT;
	endfunction

	assign moveRight = buttons[0];
	assign moveDown  = buttons[1];
	assign moveUp    = buttons[2];
	assign moveLeft  = buttons[3];

	////////////////////
	// Maze portals
	////////////////////
	always_comb begin
		rightRoomX = view.roomX + roomCoord_t'(1);
		rightRoomY = view.roomY;
		leftRoomX = view.roomX - roomCoord_t'(1);
		leftRoomY = view.roomY;
		if (view.roomX == 4'd1 && view.roomY == 4'd6) begin
			rightRoomX = 4'd1;
			rightRoomY = 4'd4;
			leftRoomX = 4'd2;
			leftRoomY = 4'd4;
		end else if (view.roomX == 4'd2 && view.roomY == 4'd5) begin
			rightRoomX = 4'd1;
			rightRoomY = 4'd5;
		end else if (view.roomX == 4'd2 && view.roomY == 4'd4) begin
			rightRoomX = 4'd1;
			rightRoomY = 4'd6;
		end else if (view.roomX == 4'd1 && view.roomY == 4'd5) begin
			leftRoomX = 4'd2;
			leftRoomY = 4'd5;
		end else if (view.roomX == 4'd1 && view.roomY == 4'd4) begin
			leftRoomX = 4'd1;
			leftRoomY = 4'd6;
		end
	end

	////////////////////
	// Position and room
	////////////////////
	always_ff @(posedge turn) begin
		if (rst) begin
			view.playerX <= START_X;
			view.playerY <= START_Y;
			view.roomX <= START_ROOM_X;
			view.roomY <= START_ROOM_Y;
			view.roomColor <= roomLookup(START_ROOM_X, START_ROOM_Y);
		end else if (step) begin
			// Later buttons win on the same axis
			if (moveRight && view.playerX < X_MAX)
				view.playerX <= bump ? view.playerX - pixelX_t'(PUSH_BACK) : view.playerX + 10'd1;
			if (moveDown && view.playerY < Y_MAX)
				view.playerY <= bump ? view.playerY - pixelY_t'(PUSH_BACK) : view.playerY + 9'd1;
			if (moveUp && view.playerY > Y_MIN)
				view.playerY <= bump ? view.playerY + pixelY_t'(PUSH_BACK) : view.playerY - 9'd1;
			if (moveLeft && view.playerX > X_MIN)
				view.playerX <= bump ? view.playerX + pixelX_t'(PUSH_BACK) : view.playerX - 10'd1;

			// Edge crossing overrides movement
			if (view.playerX >= X_MAX && view.roomX != ROOM_LIMIT) begin
				view.roomX <= rightRoomX;
				view.roomY <= rightRoomY;
				view.playerX <= ENTRY_LEFT;
			end else if (view.playerY >= Y_MAX && view.roomY != ROOM_LIMIT) begin
				view.roomY <= view.roomY + roomCoord_t'(1);
				view.playerY <= ENTRY_TOP;
			end else if (view.playerY <= Y_MIN && view.roomY != '0) begin
				view.roomY <= view.roomY - roomCoord_t'(1);
				view.playerY <= ENTRY_BOTTOM;
			end else if (view.playerX <= X_MIN && view.roomX != '0) begin
				view.roomX <= leftRoomX;
				view.roomY <= leftRoomY;
				view.playerX <= ENTRY_RIGHT;
			end

			// lags the room by one step
			view.roomColor <= roomLookup(view.roomX, view.roomY);
		end
	end

endmodule

//--- hdl/stepTimer.sv
module stepTimer
	import adventurePkg::*;
(
	input  logic turn,
	input  logic rst,
	output logic step
);

	logic [STEP_COUNT_W-1:0] count;

	// One-cycle pulse at the end of every period
	always_ff @(posedge turn) begin
		if (rst) begin
			count <= '0;
			step <= 1'b0;
		end else if (count == STEP_COUNT_W'(STEP_PERIOD - 1)) begin
			count <= '0;
			step <= 1'b1;
		end else begin
			count <= count + STEP_COUNT_W'(1);
			step <= 1'b0;
		end
	end

endmodule

//--- common/gameView.sv
// Game state shared by the state keepers and the compositor
interface gameView
	import adventurePkg::*;
();

	pixelX_t    playerX;
	pixelY_t    playerY;
	roomCoord_t roomX;
	roomCoord_t roomY;
	color_t     roomColor;

	pixelX_t  yellowKeyX;
	pixelY_t  yellowKeyY;
	pixelX_t  blackKeyX;
	pixelY_t  blackKeyY;
	logic     yellowUsed;
	logic     blackUsed;
	heldKey_t held;

	modport player (output playerX, playerY, roomX, roomY, roomColor);

	modport keys (
		input  playerX, playerY, roomX, roomY,
		output yellowKeyX, yellowKeyY, blackKeyX, blackKeyY, yellowUsed, blackUsed, held
	);

	modport render (
		input playerX, playerY, roomX, roomY, roomColor,
		input yellowKeyX, yellowKeyY, blackKeyX, blackKeyY, yellowUsed, blackUsed, held
	);

endinterface

//--- common/adventurePkg.sv
package adventurePkg;

	typedef logic [9:0] pixelX_t;
	typedef logic [8:0] pixelY_t;
	typedef logic [3:0] roomCoord_t;

	// 3-3-2 RGB, same packing as the VGA DAC
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} color_t;

	typedef enum logic [1:0] {
		HELD_NONE   = 2'd0,
		HELD_YELLOW = 2'd1,
		HELD_BLACK  = 2'd2
	} heldKey_t;

	////////////////////
	// Game pace and screen
	////////////////////
	localparam int STEP_PERIOD  = 16;
	localparam int STEP_COUNT_W = $clog2(STEP_PERIOD);

	localparam pixelX_t X_MAX        = 10'd624;
	localparam pixelX_t X_MIN        = 10'd16;
	localparam pixelY_t Y_MAX        = 9'd470;
	localparam pixelY_t Y_MIN        = 9'd10;
	localparam pixelX_t ENTRY_LEFT   = 10'd20;
	localparam pixelX_t ENTRY_RIGHT  = 10'd619;
	localparam pixelY_t ENTRY_TOP    = 9'd14;
	localparam pixelY_t ENTRY_BOTTOM = 9'd466;
	localparam roomCoord_t ROOM_LIMIT = 4'd8;
	localparam int PUSH_BACK = 7;

	localparam pixelX_t START_X         = 10'd320;
	localparam pixelY_t START_Y         = 9'd380;
	localparam roomCoord_t START_ROOM_X = 4'd3;
	localparam roomCoord_t START_ROOM_Y = 4'd5;
	localparam int PLAYER_HALF = 9;

	////////////////////
	// Keys and gates
	////////////////////
	localparam pixelX_t YELLOW_KEY_X         = 10'd128;
	localparam pixelY_t YELLOW_KEY_Y         = 9'd220;
	localparam roomCoord_t YELLOW_KEY_ROOM_X = 4'd3;
	localparam roomCoord_t YELLOW_KEY_ROOM_Y = 4'd5;
	localparam pixelX_t BLACK_KEY_X          = 10'd128;
	localparam pixelY_t BLACK_KEY_Y          = 9'd220;
	localparam roomCoord_t BLACK_KEY_ROOM_X  = 4'd4;
	localparam roomCoord_t BLACK_KEY_ROOM_Y  = 4'd7;
	localparam int KEY_W        = 32;
	localparam int KEY_H        = 8;
	localparam int KEY_ROW      = 4;    // one row of the key outline
	localparam int CARRY_OFFSET = 15;

	localparam pixelX_t GATE_X = 10'd304;
	localparam pixelY_t GATE_Y = 9'd280;
	localparam int GATE_BARS   = 4;
	localparam int GATE_PITCH  = 10;
	localparam int GATE_BAR_W  = 5;
	localparam int GATE_BAR_H  = 80;
	localparam roomCoord_t YELLOW_CASTLE_X = 4'd3;
	localparam roomCoord_t YELLOW_CASTLE_Y = 4'd5;
	localparam roomCoord_t BLACK_CASTLE_X  = 4'd1;
	localparam roomCoord_t BLACK_CASTLE_Y  = 4'd3;
	localparam pixelX_t UNLOCK_X_LO  = 10'd288;
	localparam pixelX_t UNLOCK_X_HI  = 10'd352;
	localparam pixelY_t UNLOCK_Y     = 9'd360;
	localparam pixelY_t GATE_BLOCK_Y = 9'd352;

	// Room colours
	localparam color_t COLOR_YELLOW     = 8'hFC;
	localparam color_t COLOR_BLACK      = 8'h00;
	localparam color_t COLOR_MAZE       = 8'h27;
	localparam color_t COLOR_GREEN      = 8'h1C;
	localparam color_t COLOR_DEFAULT    = 8'hFF;
	localparam color_t COLOR_KEY_ROOM   = 8'hF0;
	localparam color_t COLOR_CHALICE    = 8'h87;
	localparam color_t COLOR_BLACK_YARD = 8'hCC;
	localparam color_t COLOR_LEFT_HALL  = 8'h78;
	localparam color_t COLOR_RIGHT_HALL = 8'h90;

endpackage
